// File: source/video_pkg.sv
/*
 * video side definitions
 * raster timing constants, square defaults, bridge register map
 * coordinate, position, bridge request and video output types
 */

package video_pkg;

    // coordinate wide enough for both raster counters
    typedef logic [9:0] coord_t;

    //////////////////////////////////////////////////
    // raster timing, 400 x 512 clocks per frame
    //////////////////////////////////////////////////

    // clocks per line
    localparam coord_t h_total  = 10'd400;
    localparam coord_t h_active = 10'd320;
    localparam coord_t h_bporch = 10'd10;

    // lines per frame
    localparam coord_t v_total  = 10'd512;
    localparam coord_t v_active = 10'd240;
    localparam coord_t v_bporch = 10'd10;

    // hs lands a few clocks after vs
    localparam coord_t hs_offset = 10'd3;

    // test pattern
    localparam coord_t     square_size      = 10'd50;
    localparam coord_t     square_x_default = 10'd135;
    localparam coord_t     square_y_default = 10'd95;
    localparam logic [7:0] background_level = 8'd60;

    // bridge register map
    localparam logic [31:0] reg_square_x_addr = 32'h1000_0000;
    localparam logic [31:0] reg_square_y_addr = 32'h1000_0004;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } raster_pos_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        rd;
        logic        wr;
        logic [31:0] wr_data;
    } bridge_req_t;

    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        hs;
        logic        vs;
    } video_out_t;

endpackage

// File: source/audio_pkg.sv
/*
 * audio side definitions
 * i2s slot constants, sample and stereo types, i2s pin bundle
 */

package audio_pkg;

    // master clocks per bit clock
    localparam int sclk_div = 4;
    // bit clocks per channel slot
    localparam int slot_bits = 32;
    // active bits at the start of each slot
    localparam int sample_bits = 16;

    typedef logic signed [sample_bits-1:0] sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_sample_t;

    // pins of the i2s bus
    typedef struct packed {
        logic sclk;
        logic lrck;
        logic dac;
    } i2s_out_t;

endpackage

// File: source/square_regs.sv
/*
 * square position registers on the bridge
 * write decode and combinational read mux
 */

module square_regs (
    input  logic                     audgen_mclk,
    input  logic                     reset_n,
    input  video_pkg::bridge_req_t   bridge,
    output logic [31:0]              bridge_rd_data,
    output video_pkg::raster_pos_t   square_pos
);

    import video_pkg::*;

    //////////////////////////////////////////////////
    // register writes
    //////////////////////////////////////////////////

    // wr is a single cycle strobe, data is broadcast
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            square_pos.x <= square_x_default;
            square_pos.y <= square_y_default;
        end else if (bridge.wr) begin
            // only the low ten bits are kept
            if (bridge.addr == reg_square_x_addr) begin
                square_pos.x <= bridge.wr_data[$bits(coord_t)-1:0];
            end
            if (bridge.addr == reg_square_y_addr) begin
                square_pos.y <= bridge.wr_data[$bits(coord_t)-1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////

    // purely from addr, rd strobe not looked at
    always_comb begin
        case (bridge.addr)
            reg_square_x_addr: begin
                bridge_rd_data = 32'(square_pos.x);
            end
            reg_square_y_addr: begin
                bridge_rd_data = 32'(square_pos.y);
            end
            // unmapped space reads back zero
            default: begin
                bridge_rd_data = 32'h0;
            end
        endcase
    end

endmodule

// File: source/raster_timing.sv
/*
 * raster timing generator
 * line and frame counters, registered hs and vs pulses
 */

module raster_timing (
    input  logic                     audgen_mclk,
    input  logic                     reset_n,
    output video_pkg::raster_pos_t   pos,
    output logic                     hs,
    output logic                     vs
);

    import video_pkg::*;

    logic line_end;
    logic frame_end;

    // last clock of a line, last line of a frame
    assign line_end  = (pos.x == h_total - 10'd1);
    assign frame_end = (pos.y == v_total - 10'd1);

    //////////////////////////////////////////////////
    // x and y counters
    //////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            pos.x <= '0;
            pos.y <= '0;
        end else begin
            pos.x <= pos.x + 10'd1;
            if (line_end) begin
                pos.x <= '0;
                // frame counter steps once per line
                pos.y <= pos.y + 10'd1;
                if (frame_end) begin
                    pos.y <= '0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // sync pulses
    //////////////////////////////////////////////////

    // both one clock wide, one cycle behind the count
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            vs <= 1'b0;
            hs <= 1'b0;
        end else begin
            // new frame at 0,0
            vs <= (pos.x == '0) && (pos.y == '0);
            // new line, a few clocks after vs
            // so the two never share a cycle
            hs <= (pos.x == hs_offset);
        end
    end

endmodule

// File: source/test_pattern.sv
/*
 * test pattern stage
 * grey active area with a black square, registered de and rgb
 */

module test_pattern (
    input  logic                     audgen_mclk,
    input  logic                     reset_n,
    input  video_pkg::raster_pos_t   pos,
    input  video_pkg::raster_pos_t   square_pos,
    output logic                     de,
    output logic [23:0]              rgb
);

    import video_pkg::*;

    logic       active;
    logic       in_square;
    coord_t     visible_x;
    coord_t     visible_y;
    // one extra bit so the square edge cannot wrap
    logic [10:0] square_x_end;
    logic [10:0] square_y_end;

    assign active = (pos.x >= h_bporch) && (pos.x < h_bporch + h_active) &&
                    (pos.y >= v_bporch) && (pos.y < v_bporch + v_active);

    // pixel inside the visible area
    assign visible_x = pos.x - h_bporch;
    assign visible_y = pos.y - v_bporch;

    assign square_x_end = {1'b0, square_pos.x} + {1'b0, square_size};
    assign square_y_end = {1'b0, square_pos.y} + {1'b0, square_size};

    assign in_square = (visible_x >= square_pos.x) && ({1'b0, visible_x} < square_x_end) &&
                       (visible_y >= square_pos.y) && ({1'b0, visible_y} < square_y_end);

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            de  <= 1'b0;
            rgb <= 24'h0;
        end else begin
            de <= active;
            // blanking is black
            rgb <= 24'h0;
            if (active && !in_square) begin
                rgb <= {3{background_level}};
            end
        end
    end

endmodule

// File: source/i2s_tx.sv
/*
 * i2s transmitter
 * bit clock divider, lrck framing, 16 bit serial shifter per slot
 */

module i2s_tx (
    input  logic                       audgen_mclk,
    input  logic                       reset_n,
    input  audio_pkg::stereo_sample_t  sample,
    output audio_pkg::i2s_out_t        i2s
);

    import audio_pkg::*;

    localparam int div_w = $clog2(sclk_div);
    localparam int cnt_w = $clog2(slot_bits);

    logic [div_w-1:0] mclk_div;
    logic             sclk_fall;
    logic [cnt_w-1:0] slot_cnt;
    logic             slot_end;
    sample_t          right_hold;
    sample_t          shift_reg;

    //////////////////////////////////////////////////
    // bit clock
    //////////////////////////////////////////////////

    // sclk is the divider msb at mclk / 4
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            mclk_div <= '0;
        end else begin
            mclk_div <= mclk_div + 1'b1;
        end
    end

    assign i2s.sclk = mclk_div[div_w-1];
    // divider wraps on this edge and sclk goes low
    assign sclk_fall = (mclk_div == div_w'(sclk_div - 1));
    assign slot_end  = (slot_cnt == cnt_w'(slot_bits - 1));

    //////////////////////////////////////////////////
    // framing and shifter
    //////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_cnt   <= '0;
            i2s.lrck   <= 1'b0;
            i2s.dac    <= 1'b0;
            right_hold <= '0;
            shift_reg  <= '0;
        end else if (sclk_fall) begin
            slot_cnt <= slot_cnt + 1'b1;
            i2s.dac  <= 1'b0;
            if (slot_end) begin
                // switch channels
                i2s.lrck <= ~i2s.lrck;
                if (i2s.lrck) begin
                    // fresh sample as the left slot starts
                    // right half waits for its own slot
                    right_hold <= sample.right;
                    shift_reg  <= sample.left;
                end else begin
                    shift_reg <= right_hold;
                end
            end else if (slot_cnt < cnt_w'(sample_bits)) begin
                // msb first one bit clock after lrck moved
                i2s.dac   <= shift_reg[sample_bits-1];
                shift_reg <= shift_reg << 1;
            end
        end
    end

endmodule

// File: source/core_av_top.sv
/*
 * core top level for video and audio
 * bridge square registers, raster and pattern, i2s transmitter
 */

module core_av_top (
    input  logic                       audgen_mclk,
    input  logic                       reset_n,
    input  video_pkg::bridge_req_t     bridge,
    output logic [31:0]                bridge_rd_data,
    output video_pkg::video_out_t      video,
    input  audio_pkg::stereo_sample_t  audio_sample,
    output audio_pkg::i2s_out_t        audio
);

    import video_pkg::*;

    raster_pos_t square_pos;
    raster_pos_t raster_pos;
    logic        hs;
    logic        vs;
    logic        de;
    logic [23:0] rgb;

    //////////////////////////////////////////////////
    // bridge and video path
    //////////////////////////////////////////////////

    square_regs square_regs_i (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .bridge         (bridge),
        .bridge_rd_data (bridge_rd_data),
        .square_pos     (square_pos)
    );

    raster_timing raster_timing_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (raster_pos),
        .hs          (hs),
        .vs          (vs)
    );

    // de and rgb line up with hs and vs
    test_pattern test_pattern_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (raster_pos),
        .square_pos  (square_pos),
        .de          (de),
        .rgb         (rgb)
    );

    assign video = '{rgb: rgb, de: de, hs: hs, vs: vs};

    // audio path
    i2s_tx i2s_tx_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .sample      (audio_sample),
        .i2s         (audio)
    );

endmodule

// File: test/tb_checks.sv
/*
 * checkers for the av core
 * reference raster and square model, i2s decoder, immediate assertions
 */

module tb_checks (
    input  logic                       audgen_mclk,
    input  logic                       reset_n,
    input  video_pkg::bridge_req_t     bridge,
    input  logic [31:0]                bridge_rd_data,
    input  video_pkg::video_out_t      video,
    input  audio_pkg::stereo_sample_t  audio_sample,
    input  audio_pkg::i2s_out_t        audio,
    output int                         err_count,
    output int                         words_checked
);

    import video_pkg::*;
    import audio_pkg::*;

    int             errors = 0;
    int             words = 0;
    // clocks since reset release
    int             cnt;
    coord_t         sq_x;
    coord_t         sq_y;
    video_out_t     exp_video;
    stereo_sample_t exp_sample;
    logic [31:0]    exp_rd;
    logic [15:0]    exp_word;
    logic [15:0]    word;
    logic           sclk_q;
    logic           lrck_q;
    logic           slot_ok;
    int             bit_pos = 0;

    assign err_count     = errors;
    assign words_checked = words;

    // expected video for raster count n, square corner at sx, sy
    function automatic video_out_t pixel_at(int n, coord_t sx, coord_t sy);
        int         x;
        int         y;
        logic       in_sq;
        video_out_t v;
        x = n % 400;
        y = (n / 400) % 512;
        v = '0;
        v.vs = (x == 0) && (y == 0);
        v.hs = (x == 3);
        // 10 clocks and 10 lines of back porch
        v.de = (x >= 10) && (x < 330) && (y >= 10) && (y < 250);
        in_sq = (x - 10 >= int'(sx)) && (x - 10 < int'(sx) + 50) &&
                (y - 10 >= int'(sy)) && (y - 10 < int'(sy) + 50);
        if (v.de && !in_sq) begin
            v.rgb = {3{8'd60}};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    //////////////////////////////////////////////////
    // reference model, stepped like the DUT flops
    //////////////////////////////////////////////////

    always @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            cnt        <= 0;
            sq_x       <= square_x_default;
            sq_y       <= square_y_default;
            exp_video  <= '0;
            exp_sample <= '0;
        end else begin
            cnt       <= cnt + 1;
            // outputs show the count of the previous clock
            exp_video <= pixel_at(cnt, sq_x, sq_y);
            if (bridge.wr && bridge.addr == reg_square_x_addr) begin
                sq_x <= bridge.wr_data[9:0];
            end
            if (bridge.wr && bridge.addr == reg_square_y_addr) begin
                sq_y <= bridge.wr_data[9:0];
            end
            // left slot starts every 256 clocks, sample taken here
            if ((cnt + 1) % 256 == 0) begin
                exp_sample <= audio_sample;
            end
        end
    end

    //////////////////////////////////////////////////
    // checks at mid cycle
    //////////////////////////////////////////////////

    always @(negedge audgen_mclk) begin
        exp_rd = (bridge.addr == reg_square_x_addr) ? 32'(sq_x) :
                 (bridge.addr == reg_square_y_addr) ? 32'(sq_y) : 32'h0;
        assert (video == exp_video)
            else report_mismatch("video {rgb,de,hs,vs}", 32'(exp_video), 32'(video));
        assert (bridge_rd_data == exp_rd)
            else report_mismatch("bridge_rd_data", exp_rd, bridge_rd_data);
        // sclk is mclk / 4, lrck flips every 128 clocks
        assert (audio.sclk == ((cnt % 4) >= 2))
            else report_mismatch("audio.sclk", 32'((cnt % 4) / 2), 32'(audio.sclk));
        assert (audio.lrck == ((cnt / 128) % 2 == 1))
            else report_mismatch("audio.lrck", 32'((cnt / 128) % 2), 32'(audio.lrck));
        if (!reset_n) begin
            assert (audio.dac == 1'b0) else report_mismatch("audio.dac", 32'h0, 32'(audio.dac));
            sclk_q  = 1'b0;
            lrck_q  = 1'b0;
            slot_ok = 1'b0;
        end else if (audio.sclk && !sclk_q) begin
            // i2s decoder on rising sclk
            if (audio.lrck != lrck_q) begin
                bit_pos = 0;
                slot_ok = 1'b1;
            end else begin
                bit_pos++;
            end
            if (slot_ok && bit_pos >= 1 && bit_pos <= 16) begin
                word = {word[14:0], audio.dac};
            end else if (slot_ok) begin
                // delay bit and padding are zero
                assert (audio.dac == 1'b0)
                    else report_mismatch("audio.dac padding", 32'h0, 32'(audio.dac));
            end
            if (slot_ok && bit_pos == 16) begin
                exp_word = audio.lrck ? exp_sample.right : exp_sample.left;
                assert (word == exp_word) else report_mismatch("audio.dac word", 32'(exp_word),
                                                               32'(word));
                words++;
            end
            lrck_q = audio.lrck;
        end
        sclk_q = audio.sclk;
    end

endmodule

// File: test/tb_core_av.sv
/*
 * testbench top for the av core
 * clock, reset, watchdog, DUT instance, stimulus and closing report
 */

module tb_core_av;

    import video_pkg::*;
    import audio_pkg::*;

    localparam int frame_cycles    = 400 * 512;
    localparam int lr_frame_cycles = 256;
    localparam int audio_frames    = 16;
    // three video frames, the audio frames and some slack
    localparam int run_cycles = 3 * frame_cycles + (audio_frames + 2) * lr_frame_cycles + 4096;

    logic           audgen_mclk;
    logic           reset_n;
    bridge_req_t    bridge;
    logic [31:0]    bridge_rd_data;
    video_out_t     video;
    stereo_sample_t audio_sample;
    i2s_out_t       audio;
    int             err_count;
    int             words_checked;
    int             read_errs;
    int             tests_run;
    int             errs_before;
    int             total;
    coord_t         new_x;
    coord_t         new_y;

    core_av_top core_av_top_i (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .bridge         (bridge),
        .bridge_rd_data (bridge_rd_data),
        .video          (video),
        .audio_sample   (audio_sample),
        .audio          (audio)
    );

    tb_checks checks_i (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .bridge         (bridge),
        .bridge_rd_data (bridge_rd_data),
        .video          (video),
        .audio_sample   (audio_sample),
        .audio          (audio),
        .err_count      (err_count),
        .words_checked  (words_checked)
    );

    initial begin
        audgen_mclk = 1'b0;
        forever #10 audgen_mclk = ~audgen_mclk;
    end

    // watchdog
    initial begin
        repeat (run_cycles) @(posedge audgen_mclk);
        $display("timeout, tests still running after %0d clock cycles", run_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////
    // bridge and wait helpers
    //////////////////////////////////////////////////

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge audgen_mclk);
        bridge <= '{addr: addr, rd: 1'b0, wr: 1'b1, wr_data: data};
        @(posedge audgen_mclk);
        bridge.wr <= 1'b0;
    endtask

    task automatic bridge_read(input logic [31:0] addr, input logic [31:0] expected);
        @(posedge audgen_mclk);
        bridge.addr <= addr;
        bridge.rd   <= 1'b1;
        @(negedge audgen_mclk);
        assert (bridge_rd_data == expected) else begin
            read_errs++;
            $display("ERR %0t bridge_rd_data expected %0h actual %0h", $time, expected,
                     bridge_rd_data);
        end
        @(posedge audgen_mclk);
        bridge.rd <= 1'b0;
    endtask

    task automatic wait_vs();
        @(negedge audgen_mclk);
        while (!video.vs) begin
            @(negedge audgen_mclk);
        end
    endtask

    task automatic wait_lrck_fall();
        @(negedge audgen_mclk);
        while (!audio.lrck) begin
            @(negedge audgen_mclk);
        end
        while (audio.lrck) begin
            @(negedge audgen_mclk);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s done with %0d errors", tests_run, name,
                 err_count + read_errs - errs_before);
        errs_before = err_count + read_errs;
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        reset_n      = 1'b0;
        bridge       = '0;
        audio_sample = '0;
        read_errs    = 0;
        tests_run    = 0;
        errs_before  = 0;
        void'($urandom(32'h5096));
        repeat (4) @(posedge audgen_mclk);
        reset_n <= 1'b1;

        // defaults and an unmapped address
        bridge_read(reg_square_x_addr, 32'd135);
        bridge_read(reg_square_y_addr, 32'd95);
        bridge_read({4'h2, 28'($urandom)}, 32'h0);
        finish_test("reset_values");

        // first vs has passed, this covers one whole frame
        wait_vs();
        finish_test("raster_and_pattern");

        // move the square in line 0, before the active area
        new_x = coord_t'($urandom_range(270));
        new_y = coord_t'($urandom_range(190));
        bridge_write(reg_square_x_addr, 32'(new_x));
        bridge_write(reg_square_y_addr, 32'(new_y));
        bridge_read(reg_square_x_addr, 32'(new_x));
        bridge_read(reg_square_y_addr, 32'(new_y));
        wait_vs();
        wait_vs();
        finish_test("register_update");

        // new sample just after each left slot starts, held a whole frame
        repeat (audio_frames) begin
            wait_lrck_fall();
            @(posedge audgen_mclk);
            audio_sample <= $urandom;
        end
        wait_lrck_fall();
        wait_lrck_fall();
        if (words_checked == 0) begin
            read_errs++;
            $display("the I2S decoder never recovered a sample word");
        end
        finish_test("i2s_framing_and_data");

        total = err_count + read_errs;
        $display("%0d tests run, %0d checks failed, %0d i2s words decoded", tests_run, total,
                 words_checked);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
source/video_pkg.sv
source/audio_pkg.sv
source/square_regs.sv
source/raster_timing.sv
source/test_pattern.sv
source/i2s_tx.sv
source/core_av_top.sv
test/tb_checks.sv
test/tb_core_av.sv

// File: run_sim.sh
#!/bin/sh
# build the av core testbench with verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_core_av -f tb.f -o tb_core_av_sim

./obj_dir/tb_core_av_sim > sim.log 2>&1
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
